//--- logic/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [3:0]      alu_op_t;
    typedef logic [1:0]      mem_width_t;
    typedef logic [1:0]      wb_sel_t;
    typedef logic [2:0]      branch_t;

    localparam word_t RESET_PC = 32'h0000_0800;

    // major opcodes of the kept subset.
    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_I      = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    localparam logic [2:0] F3_ADD  = 3'b000; // also sub.
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101; // srl and sra.
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_SLL  = 4'd2;
    localparam alu_op_t ALU_SRL  = 4'd3;
    localparam alu_op_t ALU_SRA  = 4'd4;
    localparam alu_op_t ALU_SLT  = 4'd5;
    localparam alu_op_t ALU_SLTU = 4'd6;
    localparam alu_op_t ALU_AND  = 4'd7;
    localparam alu_op_t ALU_OR   = 4'd8;
    localparam alu_op_t ALU_XOR  = 4'd9;

    // same as funct3[1:0] of loads and stores.
    localparam mem_width_t MW_BYTE = 2'b00;
    localparam mem_width_t MW_HALF = 2'b01;
    localparam mem_width_t MW_WORD = 2'b10;

    localparam wb_sel_t WB_ALU  = 2'd0;
    localparam wb_sel_t WB_LOAD = 2'd1;
    localparam wb_sel_t WB_PC4  = 2'd2;
    localparam wb_sel_t WB_IMM  = 2'd3;

    localparam branch_t BR_EQ  = 3'b000;
    localparam branch_t BR_NE  = 3'b001;
    localparam branch_t BR_LT  = 3'b100;
    localparam branch_t BR_GE  = 3'b101;
    localparam branch_t BR_LTU = 3'b110;
    localparam branch_t BR_GEU = 3'b111;

endpackage

`default_nettype wire

//--- logic/core_control.sv
`default_nettype none

module core_control (
    input  logic                rst,
    input  rv_pkg::word_t       instr,
    output rv_pkg::reg_addr_t   rs1_addr,
    output rv_pkg::reg_addr_t   rs2_addr,
    output rv_pkg::reg_addr_t   rd_addr,
    output logic                reg_write,
    output rv_pkg::alu_op_t     alu_op,
    output logic                use_imm,
    output rv_pkg::wb_sel_t     wb_sel,
    output logic                mem_read,
    output logic                mem_write,
    output rv_pkg::mem_width_t  mem_width,
    output logic                branch,
    output logic                jump,
    output rv_pkg::branch_t     branch_kind,
    output logic                load_unsigned
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;

    // alt selects sub for add and sra for srl.
    function automatic alu_op_t alu_decode(input logic [2:0] f3, input logic alt);
        case (f3)
            F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  return ALU_SLL;
            F3_SLT:  return ALU_SLT;
            F3_SLTU: return ALU_SLTU;
            F3_XOR:  return ALU_XOR;
            F3_SR:   return alt ? ALU_SRA : ALU_SRL;
            F3_OR:   return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign opcode        = instr[6:0];
    assign funct3        = instr[14:12];
    assign rs1_addr      = instr[19:15];
    assign rs2_addr      = instr[24:20];
    assign rd_addr       = instr[11:7];
    assign branch_kind   = funct3;
    assign load_unsigned = funct3[2];

    always_comb begin
        reg_write = 1'b0;
        alu_op    = ALU_ADD;
        use_imm   = 1'b0;
        wb_sel    = WB_ALU;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        branch    = 1'b0;
        jump      = 1'b0;
        case (funct3[1:0])
            2'b00:   mem_width = MW_BYTE;
            2'b01:   mem_width = MW_HALF;
            default: mem_width = MW_WORD;
        endcase
        case (opcode)
            OP_R: begin
                reg_write = 1'b1;
                alu_op    = alu_decode(funct3, instr[30]);
            end
            OP_I: begin
                reg_write = 1'b1;
                use_imm   = 1'b1;
                alu_op    = alu_decode(funct3, (funct3 == F3_SR) && instr[30]); // no subi.
            end
            OP_LOAD: begin
                reg_write = 1'b1;
                use_imm   = 1'b1;
                wb_sel    = WB_LOAD;
                mem_read  = 1'b1;
            end
            OP_STORE: begin
                use_imm   = 1'b1;
                mem_write = 1'b1;
            end
            OP_BRANCH: branch = 1'b1;
            OP_LUI: begin
                reg_write = 1'b1;
                wb_sel    = WB_IMM;
            end
            OP_JAL: begin
                reg_write = 1'b1;
                jump      = 1'b1;
                wb_sel    = WB_PC4;
            end
            default: ; // unknown opcode runs as a no-op.
        endcase
        if (rst) begin
            reg_write = 1'b0;
            mem_read  = 1'b0;
            mem_write = 1'b0;
        end
    end

    always_comb begin
        assert final (!(mem_read && mem_write))
            else $error("load and store strobes both high");
    end

endmodule

`default_nettype wire

//--- logic/imm_gen.sv
`default_nettype none

module imm_gen (
    input  rv_pkg::word_t instr,
    output rv_pkg::word_t imm
);
    import rv_pkg::*;

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (instr[6:0])
            OP_I, OP_LOAD:
                imm = {{20{sign}}, instr[31:20]};
            OP_STORE:
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            OP_BRANCH: // b format, bit 0 always zero.
                imm = {{20{sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            OP_LUI:
                imm = {instr[31:12], 12'b0};
            OP_JAL:
                imm = {{12{sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default:
                imm = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/reg_file.sv
`default_nettype none

module reg_file (
    input  logic              clk,
    input  logic              rst,
    input  logic              we,
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    input  rv_pkg::reg_addr_t rd_addr,
    input  rv_pkg::word_t     rd_data,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data
);
    import rv_pkg::*;

    word_t regs [1:31]; // x0 has no storage.

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd_addr != '0)) begin
            regs[rd_addr] <= rd_data;
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    a_x0_zero: assert property (@(posedge clk)
        ((rs1_addr == '0) |-> (rs1_data == '0)) and ((rs2_addr == '0) |-> (rs2_data == '0)));

endmodule

`default_nettype wire

//--- logic/alu.sv
`default_nettype none

module alu (
    input  rv_pkg::alu_op_t alu_op,
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    output rv_pkg::word_t   result
);
    import rv_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = word_t'($signed(a) >>> shamt);
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/pc_unit.sv
`default_nettype none

module pc_unit (
    input  logic            clk,
    input  logic            rst,
    input  logic            branch,
    input  logic            jump,
    input  rv_pkg::branch_t branch_kind,
    input  rv_pkg::word_t   rs1_data,
    input  rv_pkg::word_t   rs2_data,
    input  rv_pkg::word_t   imm,
    output rv_pkg::word_t   pc,
    output rv_pkg::word_t   pc_plus4
);
    import rv_pkg::*;

    logic taken;

    always_comb begin
        case (branch_kind)
            BR_EQ:   taken = rs1_data == rs2_data;
            BR_NE:   taken = rs1_data != rs2_data;
            BR_LT:   taken = $signed(rs1_data) < $signed(rs2_data);
            BR_GE:   taken = $signed(rs1_data) >= $signed(rs2_data);
            BR_LTU:  taken = rs1_data < rs2_data;
            BR_GEU:  taken = rs1_data >= rs2_data;
            default: taken = 1'b0; // reserved funct3 falls through.
        endcase
    end

    assign pc_plus4 = pc + 32'd4;

    always_ff @(posedge clk) begin
        if (rst) pc <= RESET_PC;
        else if (jump || (branch && taken)) pc <= pc + imm;
        else pc <= pc_plus4;
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- logic/load_store.sv
`default_nettype none

module load_store (
    input  rv_pkg::mem_width_t mem_width,
    input  logic               load_unsigned,
    input  rv_pkg::word_t      rs1_data,
    input  rv_pkg::word_t      rs2_data,
    input  rv_pkg::word_t      imm,
    input  rv_pkg::word_t      data_in,
    output rv_pkg::word_t      data_addr,
    output rv_pkg::word_t      data_out,
    output rv_pkg::word_t      load_data
);
    import rv_pkg::*;

    logic byte_sign;
    logic half_sign;

    assign data_addr = rs1_data + imm;

    // zero for lbu and lhu.
    assign byte_sign = data_in[7] & ~load_unsigned;
    assign half_sign = data_in[15] & ~load_unsigned;

    always_comb begin
        case (mem_width)
            MW_BYTE: begin
                data_out  = {24'b0, rs2_data[7:0]};
                load_data = {{24{byte_sign}}, data_in[7:0]};
            end
            MW_HALF: begin
                data_out  = {16'b0, rs2_data[15:0]};
                load_data = {{16{half_sign}}, data_in[15:0]};
            end
            default: begin
                data_out  = rs2_data;
                load_data = data_in;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/rv32_core.sv
`default_nettype none

module rv32_core (
    input  logic               clk,
    input  logic               rst,
    output rv_pkg::word_t      instr_addr,
    input  rv_pkg::word_t      instr,
    output rv_pkg::word_t      data_addr,
    output rv_pkg::word_t      data_out,
    input  rv_pkg::word_t      data_in,
    output rv_pkg::mem_width_t mem_width,
    output logic               mem_write,
    output logic               mem_read
);
    import rv_pkg::*;

    reg_addr_t rs1_addr, rs2_addr, rd_addr;
    logic      reg_write, use_imm, branch, jump, load_unsigned;
    alu_op_t   alu_op;
    wb_sel_t   wb_sel;
    branch_t   branch_kind;
    word_t     imm, rs1_data, rs2_data, alu_result, load_data, pc_plus4, wb_data;

    core_control i_core_control (
        .rst(rst), .instr(instr),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rd_addr(rd_addr),
        .reg_write(reg_write), .alu_op(alu_op), .use_imm(use_imm), .wb_sel(wb_sel),
        .mem_read(mem_read), .mem_write(mem_write), .mem_width(mem_width),
        .branch(branch), .jump(jump), .branch_kind(branch_kind),
        .load_unsigned(load_unsigned)
    );

    imm_gen i_imm_gen (.instr(instr), .imm(imm));

    reg_file i_reg_file (
        .clk(clk), .rst(rst), .we(reg_write),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rd_addr(rd_addr), .rd_data(wb_data),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    alu i_alu (
        .alu_op(alu_op), .a(rs1_data), .b(use_imm ? imm : rs2_data), .result(alu_result)
    );

    pc_unit i_pc_unit (
        .clk(clk), .rst(rst), .branch(branch), .jump(jump), .branch_kind(branch_kind),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm),
        .pc(instr_addr), .pc_plus4(pc_plus4)
    );

    load_store i_load_store (
        .mem_width(mem_width), .load_unsigned(load_unsigned),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm), .data_in(data_in),
        .data_addr(data_addr), .data_out(data_out), .load_data(load_data)
    );

    // writeback source.
    assign wb_data = (wb_sel == WB_LOAD) ? load_data :
                     (wb_sel == WB_PC4)  ? pc_plus4  :
                     (wb_sel == WB_IMM)  ? imm       : alu_result;

endmodule

`default_nettype wire

//--- test/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

function automatic word_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                 input reg_addr_t rs1, input logic [2:0] f3,
                                 input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, OP_R};
endfunction

function automatic word_t i_type(input logic [6:0] op, input logic [11:0] imm,
                                 input reg_addr_t rs1, input logic [2:0] f3,
                                 input reg_addr_t rd);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic word_t s_type(input logic [11:0] imm, input reg_addr_t rs1,
                                 input reg_addr_t rs2, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
endfunction

function automatic word_t b_type(input logic [12:0] imm, input reg_addr_t rs1,
                                 input reg_addr_t rs2, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
endfunction

function automatic word_t u_type(input logic [19:0] imm, input reg_addr_t rd);
    return {imm, rd, OP_LUI};
endfunction

function automatic word_t j_type(input logic [20:0] imm, input reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
endfunction

task automatic emit(input word_t w);
    imem[prog_len] = w;
    prog_len++;
endtask

// results go to the area at x10, one word each.
task automatic store_word(input reg_addr_t rs2, inout int off);
    emit(s_type(12'(off), 5'd10, rs2, 3'b010));
    off += 4;
endtask

task automatic build_program();
    int    off;
    word_t rnd;
    off = 0;
    emit(s_type(12'd0, 5'd0, 5'd0, 3'b010)); // fetched during reset, strobe held low.
    for (int r = 1; r <= 2; r++) begin
        rnd = $urandom;
        emit(u_type(rnd[31:12], 5'(r)));
        emit(i_type(OP_I, rnd[11:0], 5'(r), 3'b000, 5'(r)));
    end
    emit(i_type(OP_I, 12'h200, 5'd0, 3'b000, 5'd10));
    for (int f = 0; f < 8; f++) begin
        emit(r_type(7'h00, 5'd2, 5'd1, 3'(f), 5'd5));
        store_word(5'd5, off);
        if (f == 0 || f == 5) begin
            emit(r_type(7'h20, 5'd2, 5'd1, 3'(f), 5'd5)); // sub and sra.
            store_word(5'd5, off);
        end
        rnd = $urandom;
        if (f == 1 || f == 5) begin
            rnd[11:5] = 7'h00;
        end
        emit(i_type(OP_I, rnd[11:0], 5'd1, 3'(f), 5'd5));
        store_word(5'd5, off);
        if (f == 5) begin
            rnd[11:5] = 7'h20;
            emit(i_type(OP_I, rnd[11:0], 5'd1, 3'(f), 5'd5));
            store_word(5'd5, off);
        end
    end
    emit(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd0)); // x0 must stay zero.
    store_word(5'd0, off);
    for (int f = 0; f < 3; f++) begin
        emit(s_type(12'(off), 5'd10, 5'd1, 3'(f)));
        off += 4;
    end
    for (int f = 0; f < 6; f++) begin
        if (f == 3) begin
            continue;
        end
        rnd = $urandom;
        emit(i_type(OP_LOAD, {4'h0, rnd[7:2], 2'b00}, 5'd0, 3'(f), 5'd6));
        store_word(5'd6, off);
    end
    for (int f = 0; f < 8; f++) begin
        if (f == 2 || f == 3) begin
            continue;
        end
        for (int k = 0; k < 3; k++) begin
            emit(b_type(13'd8, (k == 1) ? 5'd2 : 5'd1, (k == 0) ? 5'd2 : 5'd1, 3'(f)));
            emit(i_type(OP_I, 12'd1, 5'd7, 3'b000, 5'd7)); // skipped when taken.
        end
    end
    store_word(5'd7, off);
    emit(j_type(21'd8, 5'd8));
    emit(i_type(OP_I, 12'd1, 5'd7, 3'b000, 5'd7));
    store_word(5'd8, off);
    store_word(5'd7, off);
    emit(j_type(21'd0, 5'd0)); // halt loop.
endtask

`endif

//--- test/rv32_core_tb.sv
`default_nettype none

module rv32_core_tb;
    import rv_pkg::*;

    localparam int PERIOD = 40;

    logic       clk;
    logic       rst;
    word_t      instr_addr, instr, data_addr, data_out, data_in;
    mem_width_t mem_width;
    logic       mem_write, mem_read;

    word_t      imem [0:255];
    logic [7:0] dmem [0:1023];
    logic [7:0] mmem [0:1023]; // model copy of the data memory.
    int         prog_len;
    word_t      halt_pc, ioff;
    logic [9:0] daddr;

    // reference model state and its view of the current instruction.
    word_t      mpc, mi, moff, m_next_pc, m_addr, m_dout, m_wb_val;
    word_t      mregs [0:31];
    logic       m_wb, m_write, m_read;
    mem_width_t m_width;

    int reset_errs, pc_errs, strobe_errs, store_errs, load_errs;

    `include "tb_program.svh"

    rv32_core i_rv32_core (
        .clk(clk), .rst(rst), .instr_addr(instr_addr), .instr(instr),
        .data_addr(data_addr), .data_out(data_out), .data_in(data_in),
        .mem_width(mem_width), .mem_write(mem_write), .mem_read(mem_read)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    assign ioff    = instr_addr - RESET_PC;
    assign instr   = imem[ioff[9:2]];
    assign daddr   = data_addr[9:0];
    assign data_in = {dmem[daddr + 10'd3], dmem[daddr + 10'd2], dmem[daddr + 10'd1], dmem[daddr]};

    always @(posedge clk) begin
        if (mem_write) begin
            dmem[daddr] <= data_out[7:0];
            if (mem_width != MW_BYTE) dmem[daddr + 10'd1] <= data_out[15:8];
            if (mem_width == MW_WORD) begin
                dmem[daddr + 10'd2] <= data_out[23:16];
                dmem[daddr + 10'd3] <= data_out[31:24];
            end
        end
    end

    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt, input word_t a,
                                      input word_t b);
        logic signed [31:0] sa;
        sa = a;
        sa = sa >>> b[4:0];
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? word_t'(sa) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    always_comb begin
        word_t      rs1v, rs2v, imm_i, imm_s, lword;
        logic [2:0] f3;
        logic [9:0] a;
        logic       take;
        moff      = mpc - RESET_PC;
        mi        = imem[moff[9:2]];
        f3        = mi[14:12];
        rs1v      = mregs[mi[19:15]];
        rs2v      = mregs[mi[24:20]];
        imm_i     = {{20{mi[31]}}, mi[31:20]};
        imm_s     = {{20{mi[31]}}, mi[31:25], mi[11:7]};
        m_next_pc = mpc + 32'd4;
        m_wb      = 1'b0;
        m_wb_val  = '0;
        m_write   = 1'b0;
        m_read    = 1'b0;
        take      = 1'b0;
        m_addr    = rs1v + ((mi[6:0] == OP_STORE) ? imm_s : imm_i);
        a         = m_addr[9:0];
        lword     = {mmem[a + 10'd3], mmem[a + 10'd2], mmem[a + 10'd1], mmem[a]};
        m_width   = (f3[1:0] == 2'b00) ? MW_BYTE : (f3[1:0] == 2'b01) ? MW_HALF : MW_WORD;
        m_dout    = (f3[1:0] == 2'b00) ? {24'b0, rs2v[7:0]} :
                    (f3[1:0] == 2'b01) ? {16'b0, rs2v[15:0]} : rs2v;
        case (mi[6:0])
            OP_R, OP_I: begin
                m_wb     = 1'b1;
                m_wb_val = alu_ref(f3, mi[30] && (mi[6:0] == OP_R || f3 == 3'd5), rs1v,
                                   (mi[6:0] == OP_R) ? rs2v : imm_i);
            end
            OP_LOAD: begin
                m_wb   = 1'b1;
                m_read = 1'b1;
                case (f3)
                    3'd0:    m_wb_val = {{24{lword[7]}}, lword[7:0]};
                    3'd1:    m_wb_val = {{16{lword[15]}}, lword[15:0]};
                    3'd4:    m_wb_val = {24'b0, lword[7:0]};
                    3'd5:    m_wb_val = {16'b0, lword[15:0]};
                    default: m_wb_val = lword;
                endcase
            end
            OP_STORE: m_write = 1'b1;
            OP_BRANCH: begin
                case (f3)
                    3'd0:    take = rs1v == rs2v;
                    3'd1:    take = rs1v != rs2v;
                    3'd4:    take = $signed(rs1v) < $signed(rs2v);
                    3'd5:    take = $signed(rs1v) >= $signed(rs2v);
                    3'd6:    take = rs1v < rs2v;
                    3'd7:    take = rs1v >= rs2v;
                    default: take = 1'b0;
                endcase
                if (take) m_next_pc = mpc + {{20{mi[31]}}, mi[7], mi[30:25], mi[11:8], 1'b0};
            end
            OP_LUI: begin
                m_wb     = 1'b1;
                m_wb_val = {mi[31:12], 12'b0};
            end
            OP_JAL: begin
                m_wb      = 1'b1;
                m_wb_val  = mpc + 32'd4;
                m_next_pc = mpc + {{12{mi[31]}}, mi[19:12], mi[20], mi[30:21], 1'b0};
            end
            default: ;
        endcase
    end

    // model steps on the same edge as the core.
    always @(posedge clk) begin
        if (rst) begin
            mpc <= RESET_PC;
            for (int r = 0; r < 32; r++) mregs[r] <= '0;
        end else begin
            mpc <= m_next_pc;
            if (m_wb && mi[11:7] != 5'd0) mregs[mi[11:7]] <= m_wb_val;
            if (m_write) begin
                mmem[m_addr[9:0]] <= m_dout[7:0];
                if (m_width != MW_BYTE) mmem[m_addr[9:0] + 10'd1] <= m_dout[15:8];
                if (m_width == MW_WORD) begin
                    mmem[m_addr[9:0] + 10'd2] <= m_dout[23:16];
                    mmem[m_addr[9:0] + 10'd3] <= m_dout[31:24];
                end
            end
        end
    end

    a_reset_pc: assert property (@(posedge clk)
        ((rst && $past(rst)) || $fell(rst)) |-> (instr_addr == RESET_PC))
        else begin
            reset_errs++;
            $display("FAIL %0t: instr_addr %h in reset, expected %h", $time,
                     $sampled(instr_addr), RESET_PC);
        end

    a_reset_strobes: assert property (@(posedge clk) rst |-> (!mem_write && !mem_read))
        else begin
            reset_errs++;
            $display("FAIL %0t: memory strobe high during reset", $time);
        end

    a_pc: assert property (@(posedge clk) disable iff (rst) instr_addr == mpc)
        else begin
            pc_errs++;
            $display("FAIL %0t: instr_addr %h, model pc %h", $time, $sampled(instr_addr),
                     $sampled(mpc));
        end

    a_strobes: assert property (@(posedge clk) disable iff (rst)
        (mem_write == m_write) && (mem_read == m_read))
        else begin
            strobe_errs++;
            $display("FAIL %0t: strobes write %b read %b at pc %h", $time,
                     $sampled(mem_write), $sampled(mem_read), $sampled(mpc));
        end

    a_store: assert property (@(posedge clk) disable iff (rst)
        m_write |-> (data_addr == m_addr && data_out == m_dout && mem_width == m_width))
        else begin
            store_errs++;
            $display("FAIL %0t: store %h to %h width %0d, expected %h to %h width %0d",
                     $time, $sampled(data_out), $sampled(data_addr), $sampled(mem_width),
                     $sampled(m_dout), $sampled(m_addr), $sampled(m_width));
        end

    a_load: assert property (@(posedge clk) disable iff (rst)
        m_read |-> (data_addr == m_addr && mem_width == m_width))
        else begin
            load_errs++;
            $display("FAIL %0t: load from %h width %0d, expected %h width %0d", $time,
                     $sampled(data_addr), $sampled(mem_width), $sampled(m_addr),
                     $sampled(m_width));
        end

    function automatic int error_total();
        return reset_errs + pc_errs + strobe_errs + store_errs + load_errs;
    endfunction

    task automatic print_error_counts();
        $display("errors: reset %0d, pc %0d, strobe %0d, store %0d, load %0d",
                 reset_errs, pc_errs, strobe_errs, store_errs, load_errs);
    endtask

    initial begin
        void'($urandom(83596));
        rst         = 1'b1;
        prog_len    = 0;
        reset_errs  = 0;
        pc_errs     = 0;
        strobe_errs = 0;
        store_errs  = 0;
        load_errs   = 0;
        for (int i = 0; i < 256; i++) imem[i] = '0;
        for (int i = 0; i < 1024; i++) begin
            dmem[i] = 8'($urandom);
            mmem[i] = dmem[i];
        end
        build_program();
        halt_pc = RESET_PC + word_t'(4 * (prog_len - 1));
        fork
            begin
                #((prog_len + 8 + 20) * PERIOD);
                $display("timeout: core never reached the halt loop at %h", halt_pc);
                print_error_counts();
                $display("TEST FAILED");
                $finish;
            end
        join_none
        repeat (8) @(negedge clk);
        rst = 1'b0;
        while (instr_addr !== halt_pc) @(negedge clk);
        repeat (3) @(negedge clk);
        print_error_counts();
        if (error_total() == 0) $display("TEST OK");
        else $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- rv32_core.f
logic/rv_pkg.sv
logic/core_control.sv
logic/imm_gen.sv
logic/reg_file.sv
logic/alu.sv
logic/pc_unit.sv
logic/load_store.sv
logic/rv32_core.sv
+incdir+test
test/rv32_core_tb.sv
